//--- rtl/fp32_pkg.sv
`default_nettype none

package fp32_pkg;

    // ------------------------------------------------------------
    // single precision layout
    // ------------------------------------------------------------
    localparam int FP32_EXP_W = 8;
    localparam int FP32_MAN_W = 23;
    localparam int FP32_W     = 1 + FP32_EXP_W + FP32_MAN_W;

    localparam int FP32_BIAS = 127;

    // ------------------------------------------------------------
    // field view and raw view of the same word
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  sign;
        logic [FP32_EXP_W-1:0] exponent;
        logic [FP32_MAN_W-1:0] mantissa;
    } fp32_fields_t;

    typedef union packed {
        logic [FP32_W-1:0] raw;
        fp32_fields_t      fields;
    } fp32_word_u;

    // ------------------------------------------------------------
    // special results
    // ------------------------------------------------------------

    // canonical quiet NaN as produced by RISC-V F
    localparam logic [FP32_W-1:0] FP32_QNAN    = 32'h7fc0_0000;
    localparam logic [FP32_W-1:0] FP32_POS_INF = 32'h7f80_0000;

endpackage

`default_nettype wire

//--- rtl/sqrt_cmd_pkg.sv
`default_nettype none

package sqrt_cmd_pkg;
    import fp32_pkg::*;

    // 24 significand bits plus guard and round
    localparam int ROOT_BITS = 26;

    // upper radicand bits carried per command, and the zero bits below them
    localparam int SQRT_RAD_W = ROOT_BITS;
    localparam int SQRT_PAD_W = 32;

    typedef logic [4:0] sqrt_tag_t;

    typedef enum logic [1:0] {
        CLASS_NORMAL,
        CLASS_ZERO,
        CLASS_POS_INF,
        CLASS_NAN_RESULT
    } sqrt_class_t;

    // radicand and pad together are shifted out two bits per root bit,
    // so their combined width stays even
    typedef struct packed {
        sqrt_tag_t             tag;
        sqrt_class_t           op_class;
        logic                  sign;
        logic [FP32_EXP_W-1:0] exponent;
        logic [SQRT_RAD_W-1:0] radicand;
        logic [SQRT_PAD_W-1:0] pad;
    } sqrt_cmd_t;

endpackage

`default_nettype wire

//--- rtl/sqrt_exponent_stage.sv
`timescale 1ns/1ns
`default_nettype none

module sqrt_exponent_stage
    import fp32_pkg::*;
    import sqrt_cmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_operand,
    input  sqrt_tag_t   in_tag,
    output logic        push,
    output sqrt_cmd_t   push_cmd,
    input  logic        credit_return
);

    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    fp32_word_u          op;
    sqrt_class_t         operand_class;
    logic signed [9:0]   unbiased;
    logic signed [9:0]   half_exp;
    sqrt_cmd_t           next_cmd;
    logic                cmd_valid;
    logic [CREDIT_W-1:0] credits;
    logic                accept;

    assign op.raw = in_operand;

    // ------------------------------------------------------------
    // classify and prepare
    // ------------------------------------------------------------

    // subnormals fall into the zero class and keep their sign
    always_comb begin
        if (op.fields.exponent == '1 && op.fields.mantissa != '0) begin
            operand_class = CLASS_NAN_RESULT;
        end else if (op.fields.exponent == '0) begin
            operand_class = CLASS_ZERO;
        end else if (op.fields.sign) begin
            operand_class = CLASS_NAN_RESULT;
        end else if (op.fields.exponent == '1) begin
            operand_class = CLASS_POS_INF;
        end else begin
            operand_class = CLASS_NORMAL;
        end
    end

    // arithmetic shift halves toward negative infinity
    assign unbiased = 10'(op.fields.exponent) - 10'(FP32_BIAS);
    assign half_exp = unbiased >>> 1;

    always_comb begin
        next_cmd          = '0;
        next_cmd.tag      = in_tag;
        next_cmd.op_class = operand_class;
        next_cmd.sign     = op.fields.sign;
        next_cmd.exponent = FP32_EXP_W'(half_exp + 10'(FP32_BIAS));
        // an odd exponent moves one factor of two into the radicand
        if (unbiased[0]) begin
            next_cmd.radicand = {1'b1, op.fields.mantissa, 2'b00};
        end else begin
            next_cmd.radicand = {2'b01, op.fields.mantissa, 1'b0};
        end
    end

    // ------------------------------------------------------------
    // command register and credits
    // ------------------------------------------------------------
    assign push     = cmd_valid && (credits != '0);
    assign in_ready = !cmd_valid || push;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
            credits   <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            if (accept) begin
                cmd_valid <= 1'b1;
            end else if (push) begin
                cmd_valid <= 1'b0;
            end
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sqrt_cmd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sqrt_cmd_fifo
    import sqrt_cmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  sqrt_cmd_t push_cmd,
    output logic      fifo_valid,
    output sqrt_cmd_t fifo_cmd,
    input  logic      pop,
    output logic      credit_return
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    sqrt_cmd_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // the producer only pushes against a credit, so there is never overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    assign fifo_valid = (count != '0);
    assign fifo_cmd   = mem[rd_ptr];

    // every freed slot goes straight back to the producer as a credit
    assign credit_return = pop;

endmodule

`default_nettype wire

//--- rtl/sqrt_iteration.sv
`timescale 1ns/1ns
`default_nettype none

module sqrt_iteration
    import fp32_pkg::*;
    import sqrt_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fifo_valid,
    input  sqrt_cmd_t   fifo_cmd,
    output logic        pop,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_result,
    output sqrt_tag_t   out_tag
);

    localparam int REM_W = ROOT_BITS + 2;
    localparam int SR_W  = SQRT_RAD_W + SQRT_PAD_W;

    logic                  iterating;
    logic                  rounding;
    logic [4:0]            step;
    logic [ROOT_BITS-1:0]  root;
    logic [REM_W-1:0]      rem;
    logic [SR_W-1:0]       rad_sr;
    sqrt_tag_t             held_tag;
    logic [FP32_EXP_W-1:0] held_exp;

    logic [REM_W-1:0]      rem_shift;
    logic [REM_W:0]        trial;
    logic                  root_bit;

    logic                  guard;
    logic                  round_bit;
    logic                  sticky;
    logic                  round_up;
    logic [FP32_MAN_W+1:0] mant_rounded;
    fp32_word_u            rounded_word;
    fp32_word_u            special_word;

    logic [31:0]           result_q;
    sqrt_tag_t             tag_q;

    // ------------------------------------------------------------
    // one restoring step
    // ------------------------------------------------------------

    // bring down two radicand bits and try to subtract 4*root+1
    assign rem_shift = {rem[REM_W-3:0], rad_sr[SR_W-1 -: 2]};
    assign trial     = {1'b0, rem_shift} - {1'b0, root, 2'b01};
    assign root_bit  = !trial[REM_W];

    // ------------------------------------------------------------
    // round and pack
    // ------------------------------------------------------------
    assign guard     = root[1];
    assign round_bit = root[0];
    assign sticky    = (rem != '0);
    assign round_up  = guard && (round_bit || sticky || root[2]);

    assign mant_rounded = {1'b0, root[ROOT_BITS-1:2]} + (FP32_MAN_W + 2)'(round_up);

    // a carry out of the significand leaves a zero mantissa and bumps the exponent
    always_comb begin
        rounded_word.fields.sign     = 1'b0;
        rounded_word.fields.exponent = held_exp + FP32_EXP_W'(mant_rounded[FP32_MAN_W+1]);
        rounded_word.fields.mantissa = mant_rounded[FP32_MAN_W-1:0];
    end

    always_comb begin
        case (fifo_cmd.op_class)
            CLASS_ZERO: begin
                special_word.raw         = '0;
                special_word.fields.sign = fifo_cmd.sign;
            end
            CLASS_POS_INF: begin
                special_word.raw = FP32_POS_INF;
            end
            default: begin
                special_word.raw = FP32_QNAN;
            end
        endcase
    end

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    assign pop = fifo_valid && !iterating && !rounding && !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            iterating <= 1'b0;
            rounding  <= 1'b0;
            step      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (pop) begin
                if (fifo_cmd.op_class == CLASS_NORMAL) begin
                    iterating <= 1'b1;
                    step      <= '0;
                end else begin
                    out_valid <= 1'b1;
                end
            end else if (iterating) begin
                step <= step + 1'b1;
                if (step == 5'(ROOT_BITS - 1)) begin
                    iterating <= 1'b0;
                    rounding  <= 1'b1;
                end
            end else if (rounding) begin
                rounding  <= 1'b0;
                out_valid <= 1'b1;
            end
        end
    end

    // datapath and result register
    always_ff @(posedge clk) begin
        if (pop) begin
            root     <= '0;
            rem      <= '0;
            rad_sr   <= {fifo_cmd.radicand, fifo_cmd.pad};
            held_tag <= fifo_cmd.tag;
            held_exp <= fifo_cmd.exponent;
            // specials bypass the recurrence
            if (fifo_cmd.op_class != CLASS_NORMAL) begin
                result_q <= special_word.raw;
                tag_q    <= fifo_cmd.tag;
            end
        end else if (iterating) begin
            root   <= {root[ROOT_BITS-2:0], root_bit};
            rem    <= root_bit ? trial[REM_W-1:0] : rem_shift;
            rad_sr <= {rad_sr[SR_W-3:0], 2'b00};
        end else if (rounding) begin
            result_q <= rounded_word.raw;
            tag_q    <= held_tag;
        end
    end

    assign out_result = result_q;
    assign out_tag    = tag_q;

endmodule

`default_nettype wire

//--- rtl/fsqrt_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fsqrt_unit
    import sqrt_cmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_operand,
    input  sqrt_tag_t   in_tag,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_result,
    output sqrt_tag_t   out_tag
);

    logic      push;
    sqrt_cmd_t push_cmd;
    logic      credit_return;
    logic      fifo_valid;
    sqrt_cmd_t fifo_cmd;
    logic      pop;

    // ------------------------------------------------------------
    // producer, buffer, consumer
    // ------------------------------------------------------------
    sqrt_exponent_stage #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) exponent_stage_i (
        .clk, .rst,
        .in_valid, .in_ready, .in_operand, .in_tag,
        .push, .push_cmd, .credit_return
    );

    sqrt_cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) cmd_fifo_i (
        .clk, .rst,
        .push, .push_cmd,
        .fifo_valid, .fifo_cmd, .pop,
        .credit_return
    );

    sqrt_iteration iteration_i (
        .clk, .rst,
        .fifo_valid, .fifo_cmd, .pop,
        .out_valid, .out_ready, .out_result, .out_tag
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 10
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- test/fsqrt_unit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module fsqrt_unit_asserts
    import sqrt_cmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input logic                               clk,
    input logic                               rst,
    input logic                               push,
    input logic [$clog2(FIFO_DEPTH + 1)-1:0] credits,
    input logic [$clog2(FIFO_DEPTH + 1)-1:0] fifo_count,
    input logic                               pop,
    input sqrt_class_t                        pop_class,
    input logic                               out_valid,
    input logic                               out_ready,
    input logic [31:0]                        out_result,
    input sqrt_tag_t                          out_tag
);

    // ------------------------------------------------------------
    // producer to FIFO credit protocol
    // ------------------------------------------------------------

    // every credit the producer holds stands for one free FIFO slot
    a_credits_match_space: assert property (@(posedge clk) disable iff (rst)
        int'(credits) + int'(fifo_count) == FIFO_DEPTH)
        else $error("producer credits do not match the free FIFO slots");

    a_push_has_room: assert property (@(posedge clk) disable iff (rst)
        push |-> fifo_count < FIFO_DEPTH)
        else $error("push issued into a full FIFO");

    // ------------------------------------------------------------
    // consumer latency
    // ------------------------------------------------------------

    // pop edge, 26 root bits, then the rounding edge
    a_normal_latency: assert property (@(posedge clk) disable iff (rst)
        pop && pop_class == CLASS_NORMAL |-> ##28 $rose(out_valid))
        else $error("normal operand result did not appear 28 cycles after the pop");

    a_special_latency: assert property (@(posedge clk) disable iff (rst)
        pop && pop_class != CLASS_NORMAL |=> out_valid)
        else $error("special operand result did not appear right after the pop");

    // ------------------------------------------------------------
    // output handshake
    // ------------------------------------------------------------

    // a stalled result must not change or disappear
    a_result_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_tag))
        else $error("result changed while stalled by out_ready");

endmodule

bind fsqrt_unit fsqrt_unit_asserts #(
    .FIFO_DEPTH(FIFO_DEPTH)
) asserts_i (
    .clk,
    .rst,
    .push,
    .credits(exponent_stage_i.credits),
    .fifo_count(cmd_fifo_i.count),
    .pop,
    .pop_class(fifo_cmd.op_class),
    .out_valid,
    .out_ready,
    .out_result,
    .out_tag
);

`default_nettype wire

//--- test/tb_fsqrt_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fsqrt_unit
    import fp32_pkg::*;
    import sqrt_cmd_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT  = 4000;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_operand;
    sqrt_tag_t   in_tag;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_result;
    sqrt_tag_t   out_tag;

    logic [31:0] exp_result_q[$];
    sqrt_tag_t   exp_tag_q[$];
    sqrt_tag_t   next_tag;
    int          sent_count;
    int          results_seen;
    logic        saw_in_ready_low;
    logic        stream_done;

    tb_clock_gen #(.PERIOD(10)) clock_gen_i (.clk);

    fsqrt_unit #(
        .FIFO_DEPTH(4)
    ) dut_i (
        .clk, .rst,
        .in_valid, .in_ready, .in_operand, .in_tag,
        .out_valid, .out_ready, .out_result, .out_tag
    );

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    // root kept to 26 bits, then rounded to nearest-even with a sticky bit
    function automatic logic [31:0] ref_sqrt(input logic [31:0] operand);
        fp32_word_u  w;
        int          ue;
        int          res_exp;
        logic [63:0] rad;
        logic [63:0] r;
        logic [63:0] cand;
        logic [63:0] mant;
        logic        sticky_b;
        w.raw = operand;
        if (w.fields.exponent == 8'hff && w.fields.mantissa != '0) begin
            return FP32_QNAN;
        end
        if (w.fields.exponent == 8'h00) begin
            return {w.fields.sign, 31'h0};
        end
        if (w.fields.sign) begin
            return FP32_QNAN;
        end
        if (w.fields.exponent == 8'hff) begin
            return FP32_POS_INF;
        end
        ue = int'(w.fields.exponent) - FP32_BIAS;
        rad = {40'h0, 1'b1, w.fields.mantissa};
        // scale to 2^50 or 2^51 times the significand so the root has 26 bits
        if (ue % 2 != 0) begin
            rad     = rad << 28;
            res_exp = (ue - 1) / 2 + FP32_BIAS;
        end else begin
            rad     = rad << 27;
            res_exp = ue / 2 + FP32_BIAS;
        end
        r = '0;
        for (int b = 25; b >= 0; b--) begin
            cand = r | (64'd1 << b);
            if (cand * cand <= rad) begin
                r = cand;
            end
        end
        sticky_b = (r * r != rad);
        mant = r >> 2;
        if (r[1] && (r[0] || sticky_b || mant[0])) begin
            mant = mant + 1;
        end
        if (mant[24]) begin
            mant    = mant >> 1;
            res_exp = res_exp + 1;
        end
        return {1'b0, 8'(res_exp), mant[22:0]};
    endfunction

    function automatic logic [31:0] random_normal();
        return {1'b0, 8'($urandom_range(1, 254)), 23'($urandom)};
    endfunction

    function automatic logic [31:0] random_mixed();
        case ($urandom_range(0, 15))
            0:       return {1'($urandom), 31'h0};
            1:       return FP32_POS_INF;
            2:       return {1'b1, 8'($urandom_range(1, 254)), 23'($urandom)};
            3:       return {1'($urandom), 8'h00, 23'($urandom)};
            4:       return {1'($urandom), 8'hff, 23'($urandom) | 23'h1};
            default: return random_normal();
        endcase
    endfunction

    // ------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------
    task automatic fail_and_stop();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s at time %0t", why, $time);
        fail_and_stop();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] got);
        $display("[FAIL] %0t %s expected 0x%08h got 0x%08h", $time, name, expected, got);
        fail_and_stop();
    endtask

    // ------------------------------------------------------------
    // driving and waiting, always entered on a falling edge
    // ------------------------------------------------------------
    task automatic send_op(input logic [31:0] operand);
        int waited;
        waited     = 0;
        in_valid   = 1'b1;
        in_operand = operand;
        in_tag     = next_tag;
        // in_ready only moves after a rising edge so it is settled here
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > ACCEPT_TIMEOUT) begin
                abort_run("input was not accepted, in_ready stayed low too long");
            end
        end
        exp_result_q.push_back(ref_sqrt(operand));
        exp_tag_q.push_back(next_tag);
        sent_count++;
        next_tag = next_tag + 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_result_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("outstanding results did not arrive in time");
            end
        end
    endtask

    // a directed case first checks the reference against the known answer
    task automatic send_known(input logic [31:0] operand, input logic [31:0] answer);
        assert (ref_sqrt(operand) === answer)
            else report_mismatch("ref_sqrt", answer, ref_sqrt(operand));
        send_op(operand);
    endtask

    // ------------------------------------------------------------
    // comparing process
    // ------------------------------------------------------------
    task automatic check_result();
        logic [31:0] exp_result;
        sqrt_tag_t   exp_tag;
        if (exp_result_q.size() == 0) begin
            abort_run("a result was delivered with no command outstanding");
        end else begin
            exp_result = exp_result_q.pop_front();
            exp_tag    = exp_tag_q.pop_front();
            results_seen++;
            assert (out_result === exp_result)
                else report_mismatch("out_result", exp_result, out_result);
            assert (out_tag === exp_tag)
                else report_mismatch("out_tag", 32'(exp_tag), 32'(out_tag));
        end
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            check_result();
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'ha5b3549e));
        rst              = 1'b1;
        in_valid         = 1'b0;
        in_operand       = '0;
        in_tag           = '0;
        out_ready        = 1'b1;
        next_tag         = '0;
        sent_count       = 0;
        results_seen     = 0;
        saw_in_ready_low = 1'b0;
        stream_done      = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        assert (in_ready === 1'b1 && out_valid === 1'b0)
            else abort_run("in_ready or out_valid has the wrong value after reset");

        // exact squares over both exponent parities
        send_known(32'h4080_0000, 32'h4000_0000);
        send_known(32'h4110_0000, 32'h4040_0000);
        send_known(32'h3e80_0000, 32'h3f00_0000);
        send_known(32'h7180_0000, 32'h5880_0000);
        send_known(32'h0d80_0000, 32'h2680_0000);
        send_known(32'h4010_0000, 32'h3fc0_0000);
        send_known(32'h3f80_0000, 32'h3f80_0000);
        wait_for_drain();

        // operands near the top of a binade, then random normals
        send_op(32'h3f7f_ffff);
        send_op(32'h407f_ffff);
        send_op(32'h3f80_0001);
        for (int i = 0; i < 20; i++) begin
            send_op(random_normal());
        end
        wait_for_drain();

        // special operands skip the recurrence
        send_known(32'h0000_0000, 32'h0000_0000);
        send_known(32'h8000_0000, 32'h8000_0000);
        send_known(32'h7f80_0000, FP32_POS_INF);
        send_known(32'h7f80_0001, FP32_QNAN);
        send_known(32'hbf80_0000, FP32_QNAN);
        send_known(32'hff80_0000, FP32_QNAN);
        send_known(32'h8000_0123, 32'h8000_0000);
        wait_for_drain();

        // hold the output stalled while 8 commands are offered
        out_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    send_op(random_normal());
                end
            end
            begin
                repeat (200) begin
                    @(negedge clk);
                    if (!in_ready) begin
                        saw_in_ready_low = 1'b1;
                    end
                end
                out_ready = 1'b1;
            end
        join
        assert (saw_in_ready_low)
            else abort_run("in_ready never fell while the output was stalled");
        wait_for_drain();

        // mixed stream with a toggling out_ready
        fork
            begin
                for (int i = 0; i < 30; i++) begin
                    send_op(random_mixed());
                end
                wait_for_drain();
                stream_done = 1'b1;
            end
            begin
                while (!stream_done) begin
                    @(negedge clk);
                    out_ready = 1'($urandom);
                end
            end
        join
        out_ready = 1'b1;

        repeat (4) @(negedge clk);
        if (exp_result_q.size() == 0 && results_seen == sent_count) begin
            $display("ALL CHECKS PASSED");
        end else begin
            abort_run("not every command produced a result");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fsqrt_unit.f
rtl/fp32_pkg.sv
rtl/sqrt_cmd_pkg.sv
rtl/sqrt_exponent_stage.sv
rtl/sqrt_cmd_fifo.sv
rtl/sqrt_iteration.sv
rtl/fsqrt_unit.sv
test/tb_clock_gen.sv
test/fsqrt_unit_asserts.sv
test/tb_fsqrt_unit.sv

//--- Bender.yml
package:
  name: fsqrt_unit

sources:
  - rtl/fp32_pkg.sv
  - rtl/sqrt_cmd_pkg.sv
  - rtl/sqrt_exponent_stage.sv
  - rtl/sqrt_cmd_fifo.sv
  - rtl/sqrt_iteration.sv
  - rtl/fsqrt_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/fsqrt_unit_asserts.sv
      - test/tb_fsqrt_unit.sv
